// File: unified_multiplicator.f
umult_pkg.sv
umult_pe.sv
umult_array.sv
umult_ctrl_map.sv
umult_transconv_out.sv
unified_multiplicator.sv
tb_unified_multiplicator.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the unified multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f unified_multiplicator.f \
    --top-module tb_unified_multiplicator -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi
exit 1

// File: tb_unified_multiplicator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_unified_multiplicator
    import umult_pkg::*;
();

    localparam int PERIOD = 4;
    // Reset plus the cycles of each test in run order
    localparam int BUDGET_CYCLES = 4 + 1 + 7 + 16 + 11 + 17 + 8;
    localparam int MARGIN_NS = 80;

    logic                 clk;
    logic                 rst_n;
    conv_mode_e           mode;
    data_vec_t            weight_in;
    data_vec_t            ifmap_in;
    array_ctrl_t          conv_ctrl;
    transconv_ctrl_t      transconv_ctrl;
    logic [SEL_W-1:0]     done_select;
    logic signed [DW-1:0] result;
    logic [COL_W-1:0]     col_id;
    logic                 partial_valid;
    data_vec_t            conv_out;

    int checks;
    int errors;
    int test_errors;

    // Current operand lanes
    logic [DW-1:0] w [DIM];
    logic [DW-1:0] x [DIM];
    // Reference PE registers indexed [row][col]
    logic [DW-1:0] wm     [DIM][DIM] = '{default: '0};
    logic [DW-1:0] ifm    [DIM][DIM] = '{default: '0};
    logic [DW-1:0] psum_m [DIM][DIM] = '{default: '0};
    logic [DW-1:0] out_m  [DIM][DIM] = '{default: '0};

    unified_multiplicator uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .mode           (mode),
        .weight_in      (weight_in),
        .ifmap_in       (ifmap_in),
        .conv_ctrl      (conv_ctrl),
        .transconv_ctrl (transconv_ctrl),
        .done_select    (done_select),
        .result         (result),
        .col_id         (col_id),
        .partial_valid  (partial_valid),
        .conv_out       (conv_out)
    );

    always #(PERIOD / 2) clk = ~clk;

    // ========================================================================
    // Reference model and helpers
    // ========================================================================

    // Signed product cut back to DW bits
    function automatic logic [DW-1:0] wrap_mul(input logic [DW-1:0] a, input logic [DW-1:0] b);
        logic signed [2*DW-1:0] full;
        full = $signed(a) * $signed(b);
        return full[DW-1:0];
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        errors += test_errors;
        $display("test %s done, %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic next_cycle;
        @(negedge clk);
    endtask

    task automatic load_random;
        for (int k = 0; k < DIM; k++) begin
            w[k] = DW'($urandom);
            x[k] = DW'($urandom);
            weight_in[k] = w[k];
            ifmap_in[k] = x[k];
        end
    endtask

    // One reference edge where each stage reads pre-edge values
    task automatic model_edge(input logic [DIM*DIM-1:0] en_in, en_psum, en_out, clear,
                              input logic [DIM-1:0] sel);
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                if (en_out[r*DIM+c]) out_m[r][c] = psum_m[r][c];
                if (clear[r*DIM+c]) begin
                    psum_m[r][c] = '0;
                end else if (en_psum[r*DIM+c]) begin
                    psum_m[r][c] = psum_m[r][c] + wrap_mul(wm[r][c], ifm[r][c]);
                end
            end
            // Right to left so forwarding sees the old neighbour
            for (int c = DIM - 1; c >= 0; c--) begin
                if (en_in[r*DIM+c]) begin
                    wm[r][c] = w[c];
                    ifm[r][c] = (sel[r] && c != 0) ? ifm[r][c-1] : x[r];
                end
            end
        end
    endtask

    task automatic conv_step(input logic [DIM*DIM-1:0] en_in, en_psum, en_out, clear,
                             input logic [DIM-1:0] sel);
        mode = MODE_CONV;
        conv_ctrl = '0;
        conv_ctrl.en_in = en_in;
        conv_ctrl.en_psum = en_psum;
        conv_ctrl.en_out = en_out;
        conv_ctrl.clear_psum = clear;
        conv_ctrl.ifmap_sel = sel;
        model_edge(en_in, en_psum, en_out, clear, sel);
        next_cycle();
        conv_ctrl = '0;
    endtask

    // Row strobes land on the diagonal only
    task automatic tc_step(input logic [DIM-1:0] wload, iload, psum, out, clear);
        logic [DIM*DIM-1:0] d_in;
        logic [DIM*DIM-1:0] d_psum;
        logic [DIM*DIM-1:0] d_out;
        logic [DIM*DIM-1:0] d_clr;
        d_in = '0;
        d_psum = '0;
        d_out = '0;
        d_clr = '0;
        for (int r = 0; r < DIM; r++) begin
            // Either load strobe opens both operand registers
            d_in[r*DIM+r] = wload[r] | iload[r];
            d_psum[r*DIM+r] = psum[r];
            d_out[r*DIM+r] = out[r];
            d_clr[r*DIM+r] = clear[r];
        end
        mode = MODE_TRANSCONV;
        // Conv set fully on and ignored by the mux
        conv_ctrl = '1;
        transconv_ctrl = '0;
        transconv_ctrl.weight_load = wload;
        transconv_ctrl.ifmap_load = iload;
        transconv_ctrl.en_psum = psum;
        transconv_ctrl.en_output = out;
        transconv_ctrl.clear_psum = clear;
        model_edge(d_in, d_psum, d_out, d_clr, '0);
        #1;
        check("transconv_no_eject", '0, conv_out);
        next_cycle();
        transconv_ctrl = '0;
        conv_ctrl = '0;
        mode = MODE_CONV;
    endtask

    // Expects the lowest set row of a nonzero mask
    task automatic check_eject(input string name, input logic [DIM-1:0] mask);
        data_vec_t expected;
        int low;
        low = 0;
        for (int r = DIM - 1; r >= 0; r--) begin
            if (mask[r]) low = r;
        end
        for (int c = 0; c < DIM; c++) begin
            expected[c] = out_m[low][c];
        end
        mode = MODE_CONV;
        conv_ctrl = '0;
        conv_ctrl.eject = mask;
        #1;
        check(name, expected, conv_out);
        next_cycle();
        conv_ctrl = '0;
    endtask

    task automatic check_rows(input string name);
        for (int r = 0; r < DIM; r++) begin
            check_eject(name, DIM'(1) << r);
        end
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic test_reset;
        conv_ctrl.eject = '1;
        done_select = '0;
        #1;
        check("reset", '0, conv_out);
        check("reset", '0, 64'($unsigned(result)));
        check("reset", '0, 64'(partial_valid));
        next_cycle();
        conv_ctrl = '0;
        finish_test("reset");
    endtask

    task automatic test_conv_mac;
        load_random();
        conv_step('1, '0, '0, '1, '0);
        conv_step('0, '1, '0, '0, '0);
        conv_step('0, '0, '1, '0, '0);
        check_rows("conv_mac");
        finish_test("conv_mac");
    endtask

    task automatic test_accum_clear;
        conv_step('0, '0, '0, '1, '0);
        // Reload overlaps accumulate of the old operands
        repeat (3) begin
            load_random();
            conv_step('1, '1, '0, '0, '0);
        end
        conv_step('0, '1, '1, '0, '0);
        conv_step('0, '0, '1, '0, '0);
        check_rows("accum_clear");
        // Clear together with accumulate
        conv_step('0, '1, '0, '1, '0);
        conv_step('0, '0, '1, '0, '0);
        check_rows("accum_clear");
        finish_test("accum_clear");
    endtask

    task automatic test_forward_eject;
        load_random();
        conv_step('1, '0, '0, '1, 4'b0000);
        // Row 1 shifts right on each load
        load_random();
        conv_step('1, '0, '0, '0, 4'b0010);
        load_random();
        conv_step('1, '0, '0, '0, 4'b0010);
        conv_step('0, '1, '0, '0, '0);
        conv_step('0, '0, '1, '0, '0);
        check_rows("forward_eject");
        check_eject("forward_eject", 4'b1010);
        check_eject("forward_eject", 4'b1100);
        finish_test("forward_eject");
    endtask

    task automatic test_transconv_diag;
        logic [DW-1:0] expected;
        // Zero every psum and output register first
        conv_step('0, '0, '0, '1, '0);
        conv_step('0, '0, '1, '0, '0);
        load_random();
        // Even rows load by the weight strobe and odd rows by the ifmap strobe
        tc_step(4'b0101, 4'b1010, '0, '0, '1);
        tc_step('0, '0, '1, '0, '0);
        tc_step('0, '0, '0, '1, '0);
        for (int k = 0; k < 2 ** SEL_W; k++) begin
            expected = (k < DIM) ? wrap_mul(w[k], x[k]) : '0;
            done_select = SEL_W'(k);
            #1;
            check("transconv_diag", 64'(expected), 64'($unsigned(result)));
            next_cycle();
        end
        done_select = '0;
        check_rows("transconv_diag");
        finish_test("transconv_diag");
    endtask

    task automatic test_output_sync;
        logic [DIM-1:0] masks [4];
        logic [DIM-1:0] rows;
        int low;
        // Mostly nonzero lowest rows so a held id is visible
        masks = '{4'b0110, 4'b1000, 4'b1011, 4'b1100};
        for (int i = 0; i < 4; i++) begin
            rows = masks[i];
            low = 0;
            for (int r = DIM - 1; r >= 0; r--) begin
                if (rows[r]) low = r;
            end
            tc_step('0, '0, '0, rows, '0);
            check("output_sync", 64'd1, 64'(partial_valid));
            check("output_sync", 64'(low), 64'(col_id));
            // Id holds once the pulses stop
            next_cycle();
            check("output_sync", '0, 64'(partial_valid));
            check("output_sync", 64'(low), 64'(col_id));
        end
        finish_test("output_sync");
    endtask

    // ========================================================================
    // Run control
    // ========================================================================

    initial begin
        void'($urandom(32'h6424ecf3));
        clk = 1'b0;
        rst_n = 1'b0;
        mode = MODE_CONV;
        weight_in = '0;
        ifmap_in = '0;
        conv_ctrl = '0;
        transconv_ctrl = '0;
        done_select = '0;
        checks = 0;
        errors = 0;
        test_errors = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_conv_mac();
        test_accum_clear();
        test_forward_eject();
        test_transconv_diag();
        test_output_sync();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(BUDGET_CYCLES * PERIOD + MARGIN_NS);
        $display("Timeout: tests did not finish within %0d cycles", BUDGET_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: unified_multiplicator.sv
`timescale 1ns/1ps
`default_nettype none

module unified_multiplicator
    import umult_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  conv_mode_e           mode,
    input  data_vec_t            weight_in,
    input  data_vec_t            ifmap_in,
    input  array_ctrl_t          conv_ctrl,
    input  transconv_ctrl_t      transconv_ctrl,
    input  logic [SEL_W-1:0]     done_select,
    output logic signed [DW-1:0] result,
    output logic [COL_W-1:0]     col_id,
    output logic                 partial_valid,
    output data_vec_t            conv_out
);

    // Control after the mode mux
    array_ctrl_t array_ctrl;
    // Diagonal PE outputs
    data_vec_t   diag_out;

    // ========================================================================
    // Control mapping, array and transconv output stage
    // ========================================================================

    umult_ctrl_map u_ctrl_map (
        .mode           (mode),
        .conv_ctrl      (conv_ctrl),
        .transconv_ctrl (transconv_ctrl),
        .array_ctrl     (array_ctrl)
    );

    umult_array u_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (array_ctrl),
        .weight_in (weight_in),
        .ifmap_in  (ifmap_in),
        .conv_out  (conv_out),
        .diag_out  (diag_out)
    );

    // Row output strobes double as the partial event
    umult_transconv_out u_tc_out (
        .clk           (clk),
        .rst_n         (rst_n),
        .diag_out      (diag_out),
        .done_select   (done_select),
        .en_output     (transconv_ctrl.en_output),
        .result        (result),
        .col_id        (col_id),
        .partial_valid (partial_valid)
    );

endmodule

`default_nettype wire

// File: umult_transconv_out.sv
`timescale 1ns/1ps
`default_nettype none

module umult_transconv_out
    import umult_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  data_vec_t            diag_out,
    input  logic [SEL_W-1:0]     done_select,
    input  logic [DIM-1:0]       en_output,
    output logic signed [DW-1:0] result,
    output logic [COL_W-1:0]     col_id,
    output logic                 partial_valid
);

    // Lowest active row this cycle
    logic [COL_W-1:0] low_idx;

    // Diagonal lane picker, zero past the last lane
    always_comb begin
        result = '0;
        if (done_select < SEL_W'(DIM)) begin
            result = diag_out[done_select[COL_W-1:0]];
        end
    end

    // ========================================================================
    // Output sync toward the accumulator
    // ========================================================================

    // Priority encode, keep last id when idle
    always_comb begin
        low_idx = col_id;
        for (int k = DIM - 1; k >= 0; k--) begin
            if (en_output[k]) begin
                low_idx = COL_W'(k);
            end
        end
    end

    // Lines up with the output register update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            partial_valid <= 1'b0;
            col_id        <= '0;
        end else begin
            partial_valid <= |en_output;
            col_id        <= low_idx;
        end
    end

endmodule

`default_nettype wire

// File: umult_ctrl_map.sv
`timescale 1ns/1ps
`default_nettype none

module umult_ctrl_map
    import umult_pkg::*;
(
    input  conv_mode_e      mode,
    input  array_ctrl_t     conv_ctrl,
    input  transconv_ctrl_t transconv_ctrl,
    output array_ctrl_t     array_ctrl
);

    // Array control image built from the row-wise transconv set
    array_ctrl_t tc_image;

    // ========================================================================
    // Diagonal fan-out
    // ========================================================================

    always_comb begin
        // Off-diagonal PEs stay idle
        tc_image = '0;
        for (int r = 0; r < DIM; r++) begin
            // Either load strobe opens the operand registers
            tc_image.en_in[r*DIM + r]      = transconv_ctrl.weight_load[r] |
                                             transconv_ctrl.ifmap_load[r];
            tc_image.en_psum[r*DIM + r]    = transconv_ctrl.en_psum[r];
            tc_image.clear_psum[r*DIM + r] = transconv_ctrl.clear_psum[r];
            tc_image.en_out[r*DIM + r]     = transconv_ctrl.en_output[r];
        end
        tc_image.ifmap_sel = transconv_ctrl.ifmap_sel;
        // No row eject in transposed mode
        tc_image.eject     = '0;
    end

    // ========================================================================
    // Mode multiplexer
    // ========================================================================

    assign array_ctrl = (mode == MODE_TRANSCONV) ? tc_image : conv_ctrl;

endmodule

`default_nettype wire

// File: umult_array.sv
`timescale 1ns/1ps
`default_nettype none

module umult_array
    import umult_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  array_ctrl_t ctrl,
    input  data_vec_t   weight_in,
    input  data_vec_t   ifmap_in,
    output data_vec_t   conv_out,
    output data_vec_t   diag_out
);

    // Per-PE ifmap and output registers, indexed [row][col]
    logic [DIM-1:0][DIM-1:0][DW-1:0] ifmap_grid;
    logic [DIM-1:0][DIM-1:0][DW-1:0] out_grid;

    // ========================================================================
    // PE grid
    // ========================================================================

    for (genvar r = 0; r < DIM; r++) begin : g_row
        for (genvar c = 0; c < DIM; c++) begin : g_col
            localparam int IDX = r * DIM + c;

            logic signed [DW-1:0] ifmap_src;

            // Column 0 always sees the external lane
            if (c == 0) begin : g_edge
                assign ifmap_src = ifmap_in[r];
            end else begin : g_inner
                // Forwarded operand is the neighbour value before the edge
                assign ifmap_src = ctrl.ifmap_sel[r] ? ifmap_grid[r][c-1]
                                                     : ifmap_in[r];
            end

            umult_pe u_pe (
                .clk        (clk),
                .rst_n      (rst_n),
                .en_in      (ctrl.en_in[IDX]),
                .en_psum    (ctrl.en_psum[IDX]),
                .en_out     (ctrl.en_out[IDX]),
                .clear_psum (ctrl.clear_psum[IDX]),
                // Weight lane follows the column
                .weight_d   (weight_in[c]),
                .ifmap_d    (ifmap_src),
                .ifmap_q    (ifmap_grid[r][c]),
                .out_q      (out_grid[r][c])
            );
        end
    end

    // ========================================================================
    // Row eject selector
    // ========================================================================

    // Lowest ejected row wins, zero when nothing ejects
    always_comb begin
        conv_out = '0;
        for (int r = DIM - 1; r >= 0; r--) begin
            if (ctrl.eject[r]) begin
                conv_out = out_grid[r];
            end
        end
    end

    // Diagonal tap for the transconv result path
    for (genvar k = 0; k < DIM; k++) begin : g_diag
        assign diag_out[k] = out_grid[k][k];
    end

endmodule

`default_nettype wire

// File: umult_pe.sv
`timescale 1ns/1ps
`default_nettype none

module umult_pe
    import umult_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en_in,
    input  logic                 en_psum,
    input  logic                 en_out,
    input  logic                 clear_psum,
    input  logic signed [DW-1:0] weight_d,
    input  logic signed [DW-1:0] ifmap_d,
    output logic signed [DW-1:0] ifmap_q,
    output logic signed [DW-1:0] out_q
);

    logic signed [DW-1:0] weight_q;
    logic signed [DW-1:0] psum_q;
    logic signed [DW-1:0] product;

    // Product of the held operands, wraps to DW bits
    assign product = weight_q * ifmap_q;

    // ========================================================================
    // Operand registers
    // ========================================================================

    // Weight and ifmap load together on en_in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_q <= '0;
            ifmap_q  <= '0;
        end else if (en_in) begin
            weight_q <= weight_d;
            ifmap_q  <= ifmap_d;
        end
    end

    // ========================================================================
    // Accumulator and output register
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum_q <= '0;
        end else if (clear_psum) begin
            // Clear wins over accumulate
            psum_q <= '0;
        end else if (en_psum) begin
            psum_q <= psum_q + product;
        end
    end

    // Snapshot of psum before this edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (en_out) begin
            out_q <= psum_q;
        end
    end

endmodule

`default_nettype wire

// File: umult_pkg.sv
`default_nettype none

package umult_pkg;

    // ========================================================================
    // Array geometry and data sizes
    // ========================================================================

    // Signed operand and accumulator width
    localparam int DW    = 16;
    // Rows and columns of the square PE grid
    localparam int DIM   = 4;
    // Diagonal result select, one code past the last lane
    localparam int SEL_W = 3;
    // Column id handed to the accumulation stage
    localparam int COL_W = 2;

    // Which controller owns the array
    typedef enum logic {
        MODE_CONV      = 1'b0,
        MODE_TRANSCONV = 1'b1
    } conv_mode_e;

    // ========================================================================
    // Control bundles
    // ========================================================================

    // Full per-PE control set, bit index is row*DIM+col
    typedef struct packed {
        logic [DIM*DIM-1:0] en_in;
        logic [DIM*DIM-1:0] en_psum;
        logic [DIM*DIM-1:0] en_out;
        logic [DIM*DIM-1:0] clear_psum;
        // Per row, forward ifmap from left neighbour
        logic [DIM-1:0]     ifmap_sel;
        // Per row, drive conv_out from this row
        logic [DIM-1:0]     eject;
    } array_ctrl_t;

    // Row-wise control from the transposed-convolution FSM
    typedef struct packed {
        logic [DIM-1:0] weight_load;
        logic [DIM-1:0] ifmap_load;
        logic [DIM-1:0] en_psum;
        logic [DIM-1:0] clear_psum;
        logic [DIM-1:0] en_output;
        logic [DIM-1:0] ifmap_sel;
    } transconv_ctrl_t;

    // DIM lanes of DW bits, lane k in the k-th slice
    typedef logic signed [DIM-1:0][DW-1:0] data_vec_t;

endpackage

`default_nettype wire
